//--- hdc_encoder_top.f
hdc_pkg.sv
item_memory.sv
mem_arbiter.sv
encode_core.sv
bundle_counter.sv
bundle_buffer.sv
hdc_encoder_top.sv
tb_clk_gen.sv
tb_hdc_encoder.sv

//--- Makefile
TOP       ?= tb_hdc_encoder
FILELIST  ?= hdc_encoder_top.f
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_hdc_encoder.sv
`timescale 1ns/1ps

module tb_hdc_encoder
    import hdc_pkg::*;
;

    // cycles a core may stay busy before it counts as hung
    localparam int CORE_TIMEOUT = 64;
    localparam int N_RANDOM     = 40;
    localparam int CNT_MAX      = (1 << CNT_W) - 1;

    logic                       clk;
    logic                       arst_n;
    logic [N_CORES-1:0]         sample_v;
    logic [N_CORES*FEAT_W-1:0]  sample_feat;
    logic [N_CORES*LEVEL_W-1:0] sample_level;
    logic [N_CORES-1:0]         core_busy;
    logic                       clear;
    logic                       stream_v;
    logic                       last_stream;
    logic [DIM-1:0]             sign_bit;
    logic [STREAM_W-1:0]        stream_d;

    // reference model state
    int                  ones_cnt [DIM];
    int                  total_cnt [DIM];
    logic [DIM-1:0]      exp_sign;
    logic [STREAM_W-1:0] exp_stream;
    // check enables raised by the stimulus
    logic                rst_chk_en;
    logic                sign_chk_en;
    int                  value_errors;
    int                  timeouts;
    int unsigned         seed_val;

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    hdc_encoder_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_v     (sample_v),
        .sample_feat  (sample_feat),
        .sample_level (sample_level),
        .core_busy    (core_busy),
        .clear        (clear),
        .stream_v     (stream_v),
        .last_stream  (last_stream),
        .sign_bit     (sign_bit),
        .stream_d     (stream_d)
    );

    // bitwise rotation with bit i moving up by amt
    function automatic logic [DIM-1:0] rotate_left(input logic [DIM-1:0] vec, input int amt);
        logic [DIM-1:0] res;
        res = '0;
        for (int i = 0; i < DIM; i++) begin
            res[(i + amt) % DIM] = vec[i];
        end
        return res;
    endfunction

    // base vector of feature f
    function automatic logic [DIM-1:0] item_vector(input int f);
        return rotate_left(ITEM_SEED, f * ITEM_STRIDE);
    endfunction

    // strict majority per dimension, so ties and empty dimensions give 0
    function automatic logic [DIM-1:0] majority_vector();
        logic [DIM-1:0] res;
        for (int j = 0; j < DIM; j++) begin
            res[j] = (2 * ones_cnt[j]) > total_cnt[j];
        end
        return res;
    endfunction

    task automatic add_vote(input logic [DIM-1:0] vec);
        for (int j = 0; j < DIM; j++) begin
            if (total_cnt[j] < CNT_MAX) begin
                total_cnt[j]++;
            end
            if (vec[j] && ones_cnt[j] < CNT_MAX) begin
                ones_cnt[j]++;
            end
        end
    endtask

    task automatic reset_votes();
        for (int j = 0; j < DIM; j++) begin
            ones_cnt[j]  = 0;
            total_cnt[j] = 0;
        end
    endtask

    // one-cycle sample on core c
    // its vote goes into the model right away
    task automatic drive_sample(input int c, input int f, input int l);
        sample_v[c]                         <= 1'b1;
        sample_feat[c*FEAT_W +: FEAT_W]     <= FEAT_W'(f);
        sample_level[c*LEVEL_W +: LEVEL_W]  <= LEVEL_W'(l);
        add_vote(rotate_left(item_vector(f), l));
    endtask

    // call one edge after the accepting edge
    task automatic wait_idle();
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (core_busy != '0 && cnt < CORE_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        for (int c = 0; c < N_CORES; c++) begin
            if (core_busy[c]) begin
                $display("timeout: core %0d hung, busy never fell and no store came", c);
                timeouts++;
            end
        end
    endtask

    // counters settle one edge after the store
    task automatic check_sign();
        @(posedge clk);
        exp_sign    = majority_vector();
        sign_chk_en = 1'b1;
        repeat (2) @(posedge clk);
        sign_chk_en = 1'b0;
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        reset_votes();
        check_sign();
    endtask

    // random samples with each core re-issued once its busy drops
    task automatic run_contention(input int n_samples);
        int st [N_CORES];
        int age [N_CORES];
        int issued;
        int done_cnt;
        int guard;
        issued   = 0;
        done_cnt = 0;
        guard    = 0;
        for (int c = 0; c < N_CORES; c++) begin
            st[c]  = 0;
            age[c] = 0;
        end
        while (done_cnt < n_samples && guard < CORE_TIMEOUT * n_samples) begin
            @(posedge clk);
            guard++;
            sample_v <= '0;
            for (int c = 0; c < N_CORES; c++) begin
                // 1 means issued
                // 2 means busy seen
                if (st[c] == 1 && core_busy[c]) begin
                    st[c] = 2;
                end else if (st[c] == 2 && !core_busy[c]) begin
                    st[c] = 0;
                    done_cnt++;
                end
                if (st[c] != 0) begin
                    age[c]++;
                    if (age[c] > CORE_TIMEOUT) begin
                        $display("timeout: core %0d hung during the contention run", c);
                        timeouts++;
                        st[c] = 0;
                        done_cnt++;
                    end
                end
                if (st[c] == 0 && issued < n_samples) begin
                    drive_sample(c, $urandom % N_FEAT, $urandom % (1 << LEVEL_W));
                    issued++;
                    st[c]  = 1;
                    age[c] = 0;
                end
            end
        end
        if (done_cnt < n_samples) begin
            $display("timeout: contention run stopped with %0d of %0d samples done",
                     done_cnt, n_samples);
            timeouts++;
        end
    endtask

    task automatic stream_beat(input logic upper);
        @(posedge clk);
        stream_v    <= 1'b1;
        last_stream <= upper;
        @(posedge clk);
        stream_v    <= 1'b0;
        // select flips while idle and stream_d must hold
        last_stream <= ~upper;
        repeat (3) @(posedge clk);
    endtask

    // stream register model
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_stream <= '0;
        end else if (stream_v) begin
            exp_stream <= last_stream ? exp_sign[DIM-1:STREAM_W] : exp_sign[STREAM_W-1:0];
        end
    end

    // all checks sample on the falling edge away from any update
    assert property (@(negedge clk) rst_chk_en |-> (core_busy == '0 && sign_bit == '0
                                                    && stream_d == '0))
    else begin
        value_errors = value_errors + 1;
        $display("[FAIL] reset core_busy=0x%h sign_bit=0x%h stream_d=0x%h expected 0x0",
                 core_busy, sign_bit, stream_d);
    end

    assert property (@(negedge clk) disable iff (!arst_n) sign_chk_en |-> sign_bit == exp_sign)
    else begin
        value_errors = value_errors + 1;
        $display("[FAIL] sign_bit expected 0x%h got 0x%h", exp_sign, sign_bit);
    end

    assert property (@(negedge clk) disable iff (!arst_n) stream_d == exp_stream)
    else begin
        value_errors = value_errors + 1;
        $display("[FAIL] stream_d expected 0x%h got 0x%h", exp_stream, stream_d);
    end

    // an accepted sample raises busy one cycle later
    for (genvar c = 0; c < N_CORES; c++) begin : g_busy_chk
        assert property (@(negedge clk) disable iff (!arst_n)
                         (sample_v[c] && !core_busy[c]) |=> core_busy[c])
        else begin
            value_errors = value_errors + 1;
            $display("[FAIL] core_busy[%0d] expected 0x1 got 0x%h", c, core_busy[c]);
        end
    end

    initial begin
        arst_n       = 1'b0;
        sample_v     = '0;
        sample_feat  = '0;
        sample_level = '0;
        clear        = 1'b0;
        stream_v     = 1'b0;
        last_stream  = 1'b0;
        rst_chk_en   = 1'b0;
        sign_chk_en  = 1'b0;
        exp_sign     = '0;
        value_errors = 0;
        timeouts     = 0;
        seed_val     = $urandom(23);
        reset_votes();

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        rst_chk_en = 1'b1;
        repeat (3) @(posedge clk);
        rst_chk_en = 1'b0;

        // single encode on core 2
        drive_sample(2, 6, 5);
        @(posedge clk);
        sample_v <= '0;
        wait_idle();
        check_sign();

        // three-way majority and a fourth vector for 2-2 ties
        pulse_clear();
        @(posedge clk);
        drive_sample(0, 1, 2);
        drive_sample(1, 5, 7);
        drive_sample(2, 9, 11);
        @(posedge clk);
        sample_v <= '0;
        wait_idle();
        check_sign();
        drive_sample(3, 12, 3);
        @(posedge clk);
        sample_v <= '0;
        wait_idle();
        check_sign();

        // four cores fighting for the item memory
        pulse_clear();
        run_contention(N_RANDOM);
        @(posedge clk);
        sample_v <= '0;
        wait_idle();
        check_sign();

        // both halves of the majority vector
        stream_beat(1'b0);
        stream_beat(1'b1);

        // clear and then one fresh sample
        pulse_clear();
        drive_sample(1, 14, 15);
        @(posedge clk);
        sample_v <= '0;
        wait_idle();
        check_sign();
        repeat (2) @(posedge clk);

        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // half of the 4 ns period
    localparam realtime HALF_PERIOD = 2.0;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- hdc_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_encoder_top
    import hdc_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    // samples, one slot per core
    input  logic [N_CORES-1:0]         sample_v,
    input  logic [N_CORES*FEAT_W-1:0]  sample_feat,
    input  logic [N_CORES*LEVEL_W-1:0] sample_level,
    output logic [N_CORES-1:0]         core_busy,
    // bundling control and output
    input  logic                       clear,
    input  logic                       stream_v,
    input  logic                       last_stream,
    output logic [DIM-1:0]             sign_bit,
    output logic [STREAM_W-1:0]        stream_d
);

    // cores to arbiter
    logic [N_CORES-1:0]        mem_req;
    logic [N_CORES*FEAT_W-1:0] mem_addr;
    logic [N_CORES-1:0]        mem_gnt;
    logic [N_CORES-1:0]        mem_rvalid;
    logic [DIM-1:0]            mem_rdata;
    // arbiter to item memory
    logic                      rd_en;
    logic [FEAT_W-1:0]         rd_addr;
    logic [DIM-1:0]            rd_data;
    // cores to bundle buffer
    logic [N_CORES-1:0]        store;
    logic [N_CORES*DIM-1:0]    core_result;

    // encoding cores, all identical
    for (genvar c = 0; c < N_CORES; c++) begin : g_core
        encode_core u_core (
            .clk          (clk),
            .arst_n       (arst_n),
            .sample_v     (sample_v[c]),
            .sample_feat  (sample_feat[c*FEAT_W +: FEAT_W]),
            .sample_level (sample_level[c*LEVEL_W +: LEVEL_W]),
            .busy         (core_busy[c]),
            .mem_req      (mem_req[c]),
            .mem_addr     (mem_addr[c*FEAT_W +: FEAT_W]),
            .mem_gnt      (mem_gnt[c]),
            .mem_rvalid   (mem_rvalid[c]),
            .mem_rdata    (mem_rdata),
            .store        (store[c]),
            .core_result  (core_result[c*DIM +: DIM])
        );
    end

    // shared item memory access
    mem_arbiter u_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    item_memory u_item_memory (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // majority vote and stream out
    bundle_buffer u_bundle_buffer (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .store       (store),
        .core_result (core_result),
        .stream_v    (stream_v),
        .last_stream (last_stream),
        .sign_bit    (sign_bit),
        .stream_d    (stream_d)
    );

endmodule

`default_nettype wire

//--- bundle_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_buffer
    import hdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   clear,
    // one store strobe per core
    input  logic [N_CORES-1:0]     store,
    // core c occupies bits c*DIM upward
    input  logic [N_CORES*DIM-1:0] core_result,
    input  logic                   stream_v,
    input  logic                   last_stream,
    output logic [DIM-1:0]         sign_bit,
    output logic [STREAM_W-1:0]    stream_d
);

    // one vote counter per dimension
    for (genvar j = 0; j < DIM; j++) begin : g_dim
        // bit j of each core, in core order
        logic [N_CORES-1:0] dim_bits;

        for (genvar c = 0; c < N_CORES; c++) begin : g_core
            assign dim_bits[c] = core_result[c*DIM + j];
        end

        bundle_counter u_counter (
            .clk         (clk),
            .arst_n      (arst_n),
            .clear       (clear),
            .store       (store),
            .core_result (dim_bits),
            .sign_bit    (sign_bit[j])
        );
    end

    // output stream
    // two beats per vector
    // last_stream picks the upper half
    // updates the cycle after stream_v, holds otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_d <= '0;
        end else if (stream_v) begin
            if (last_stream) begin
                stream_d <= sign_bit[DIM-1:STREAM_W];
            end else begin
                stream_d <= sign_bit[STREAM_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- bundle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_counter
    import hdc_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clear,
    input  logic [N_CORES-1:0] store,
    // this dimension's bit from every core, core 0 in bit 0
    input  logic [N_CORES-1:0] core_result,
    output logic               sign_bit
);

    logic [CNT_W-1:0] ones_q;
    logic [CNT_W-1:0] total_q;
    // votes arriving this cycle
    logic [CNT_W-1:0] n_ones;
    logic [CNT_W-1:0] n_total;
    // one extra bit to catch overflow
    logic [CNT_W:0]   ones_sum;
    logic [CNT_W:0]   total_sum;

    // count storing cores, and those voting one
    always_comb begin
        n_ones  = '0;
        n_total = '0;
        for (int c = 0; c < N_CORES; c++) begin
            n_total = n_total + CNT_W'(store[c]);
            n_ones  = n_ones + CNT_W'(store[c] & core_result[c]);
        end
    end

    assign ones_sum  = {1'b0, ones_q} + {1'b0, n_ones};
    assign total_sum = {1'b0, total_q} + {1'b0, n_total};

    // saturating vote counters
    // clear wins over a store in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ones_q  <= '0;
            total_q <= '0;
        end else if (clear) begin
            ones_q  <= '0;
            total_q <= '0;
        end else begin
            ones_q  <= ones_sum[CNT_W] ? '1 : ones_sum[CNT_W-1:0];
            total_q <= total_sum[CNT_W] ? '1 : total_sum[CNT_W-1:0];
        end
    end

    // strict majority of ones, ties and empty count give 0
    assign sign_bit = ({ones_q, 1'b0} > {1'b0, total_q});

endmodule

`default_nettype wire

//--- encode_core.sv
`timescale 1ns/1ps
`default_nettype none

module encode_core
    import hdc_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    // sample input
    input  logic               sample_v,
    input  logic [FEAT_W-1:0]  sample_feat,
    input  logic [LEVEL_W-1:0] sample_level,
    output logic               busy,
    // item memory access via the arbiter
    output logic               mem_req,
    output logic [FEAT_W-1:0]  mem_addr,
    input  logic               mem_gnt,
    input  logic               mem_rvalid,
    input  logic [DIM-1:0]     mem_rdata,
    // result towards the bundle buffer
    output logic               store,
    output logic [DIM-1:0]     core_result
);

    logic [1:0]         state_q;
    // latched sample
    logic [FEAT_W-1:0]  feat_q;
    logic [LEVEL_W-1:0] level_q;
    logic               accept;

    // new sample only taken while idle
    // samples offered while busy are dropped
    assign accept = sample_v && (state_q == ST_IDLE);

    // controller
    // idle -> request until granted -> wait one cycle for data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            store   <= 1'b0;
        end else begin
            // store is a single-cycle strobe
            store <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (sample_v) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_gnt) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // data arrives, busy falls with the store pulse
                    if (mem_rvalid) begin
                        state_q <= ST_IDLE;
                        store   <= 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // sample fields captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            feat_q  <= sample_feat;
            level_q <= sample_level;
        end
    end

    // bind by rotation
    // only sampled downstream while store is high
    always_ff @(posedge clk) begin
        if (mem_rvalid && (state_q == ST_WAIT)) begin
            core_result <= rotl(mem_rdata, level_q);
        end
    end

    assign busy     = (state_q != ST_IDLE);
    // request and address held until the grant
    assign mem_req  = (state_q == ST_REQ);
    assign mem_addr = feat_q;

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import hdc_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    // core side
    input  logic [N_CORES-1:0]        mem_req,
    input  logic [N_CORES*FEAT_W-1:0] mem_addr,
    output logic [N_CORES-1:0]        mem_gnt,
    output logic [N_CORES-1:0]        mem_rvalid,
    output logic [DIM-1:0]            mem_rdata,
    // item memory side
    output logic                      rd_en,
    output logic [FEAT_W-1:0]         rd_addr,
    input  logic [DIM-1:0]            rd_data
);

    // core with highest priority this cycle
    logic [CORE_ID_W-1:0] rr_ptr;
    // winner of the current cycle
    logic [CORE_ID_W-1:0] gnt_idx;
    logic                 gnt_any;
    // grant seen one cycle ago, steers the read-valid pulse
    logic [N_CORES-1:0]   gnt_q;

    // round-robin pick
    // scan from rr_ptr upward, wrapping at N_CORES
    always_comb begin
        logic [CORE_ID_W-1:0] cand;
        mem_gnt = '0;
        gnt_any = 1'b0;
        gnt_idx = '0;
        cand    = '0;
        for (int i = 0; i < N_CORES; i++) begin
            cand = rr_ptr + CORE_ID_W'(i);
            // first requester found wins
            if (!gnt_any && mem_req[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cand;
            end
        end
        // at most one grant per cycle
        mem_gnt[gnt_idx] = gnt_any;
    end

    // winner's address straight to the memory
    assign rd_en   = gnt_any;
    assign rd_addr = mem_addr[gnt_idx*FEAT_W +: FEAT_W];

    // pointer moves just past the granted core
    // grant delayed to line up with the memory latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr <= '0;
            gnt_q  <= '0;
        end else begin
            if (gnt_any) begin
                rr_ptr <= gnt_idx + CORE_ID_W'(1);
            end
            gnt_q <= mem_gnt;
        end
    end

    // read data goes to everyone, valid only to the owner
    assign mem_rdata  = rd_data;
    assign mem_rvalid = gnt_q;

endmodule

`default_nettype wire

//--- item_memory.sv
`timescale 1ns/1ps
`default_nettype none

module item_memory
    import hdc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              rd_en,
    input  logic [FEAT_W-1:0] rd_addr,
    output logic [DIM-1:0]    rd_data
);

    // one base hypervector per feature
    logic [DIM-1:0] item_tbl [N_FEAT];

    // table load
    // entry f is the seed rotated by f strides
    // loaded while reset is low, constant afterwards
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int f = 0; f < N_FEAT; f++) begin
                item_tbl[f] <= rotl(ITEM_SEED, f * ITEM_STRIDE);
            end
        end
    end

    // registered read port
    // data appears the cycle after rd_en
    // held when no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= item_tbl[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdc_pkg.sv
package hdc_pkg;

    // hypervector geometry
    localparam int unsigned DIM      = 128;
    // output beat is half a hypervector
    localparam int unsigned STREAM_W = DIM / 2;

    // encoding cores sharing the item memory
    localparam int unsigned N_CORES   = 4;
    localparam int unsigned CORE_ID_W = 2;

    // sample fields
    localparam int unsigned FEAT_W  = 4;
    localparam int unsigned N_FEAT  = 16;
    localparam int unsigned LEVEL_W = 4;

    // per-dimension vote counter width
    localparam int unsigned CNT_W = 8;

    // item memory generation rule
    localparam logic [DIM-1:0] ITEM_SEED   = 128'h9e37_79b9_7f4a_7c15_f39c_c060_5ced_c834;
    localparam int unsigned    ITEM_STRIDE = 9;

    // encode core controller states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    // rotate a hypervector left, amount taken modulo DIM
    function automatic logic [DIM-1:0] rotl(input logic [DIM-1:0] vec, input int unsigned amt);
        int unsigned sh;
        sh = amt % DIM;
        // a zero shift leaves the right term empty
        return (vec << sh) | (vec >> (DIM - sh));
    endfunction

endpackage
